// ==== design/aes_encrypt_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_encrypt_top
  import aes_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         data_valid,
  output logic         data_ready,
  input  aes_state_u   data_in,
  input  logic         keys_valid,
  input  aes_key_set_t round_keys,
  output aes_state_u   data_out,
  output logic         encryption_valid
);

  aes_key_set_t key_set;

  // Slot 0 is the issue stage, slot i is the output of round i
  aes_beat_t    round_beat [0:aes_num_rounds];

  // ==============================
  // Issue and initial key add
  // ==============================
  aes_issue_ctrl u_issue_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_valid (data_valid),
    .data_in    (data_in),
    .keys_valid (keys_valid),
    .round_keys (round_keys),
    .data_ready (data_ready),
    .key_set    (key_set),
    .issue_beat (round_beat[0])
  );

  // ==============================
  // Ten rounds, three stages each
  // ==============================
  for (genvar i = 1; i <= aes_num_rounds; i++) begin : g_round
    aes_round #(
      .final_round (i == aes_num_rounds)
    ) u_round (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_beat   (round_beat[i-1]),
      .round_key (key_set[i]),
      .out_beat  (round_beat[i])
    );
  end

  // Ciphertext and its one-cycle strobe
  assign data_out         = round_beat[aes_num_rounds].state;
  assign encryption_valid = round_beat[aes_num_rounds].valid;

endmodule

`default_nettype wire

// ==== design/aes_issue_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_issue_ctrl
  import aes_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         data_valid,
  input  aes_state_u   data_in,
  input  logic         keys_valid,
  input  aes_key_set_t round_keys,
  output logic         data_ready,
  output aes_key_set_t key_set,
  output aes_beat_t    issue_beat
);

  aes_state_u data_reg;
  aes_state_u issue_state;
  logic       data_held;
  logic       keys_present;
  logic       issue_valid;
  logic       accept;
  logic       issue;

  // One block in the holding register at a time
  assign data_ready = !data_held;
  assign accept     = data_valid && data_ready;
  assign issue      = data_held && keys_present;

  // Hold and issue control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_held    <= 1'b0;
      keys_present <= 1'b0;
      issue_valid  <= 1'b0;
    end else begin
      issue_valid <= issue;
      if (keys_valid) begin
        keys_present <= 1'b1;
      end
      // Issue and accept never share an edge, data_ready is low while held
      if (accept) begin
        data_held <= 1'b1;
      end else if (issue) begin
        data_held <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (accept) begin
      data_reg <= data_in;
    end
    if (keys_valid) begin
      key_set <= round_keys;
    end
    // Initial AddRoundKey
    if (issue) begin
      issue_state.flat <= data_reg.flat ^ key_set[0];
    end
  end

  assign issue_beat = '{valid: issue_valid, state: issue_state};

endmodule

`default_nettype wire

// ==== design/aes_mix_add.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_mix_add
  import aes_pkg::*;
#(
  parameter bit final_round = 1'b0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  aes_beat_t  in_beat,
  input  aes_state_u round_key,
  output aes_beat_t  out_beat
);

  aes_state_u mixed;
  aes_state_u state_q;
  logic       valid_q;

  // One column times the fixed MixColumns matrix
  function automatic logic [0:3][7:0] mix_column(input logic [0:3][7:0] a);
    logic [0:3][7:0] m;
    m[0] = aes_xtime(a[0]) ^ aes_xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
    m[1] = a[0] ^ aes_xtime(a[1]) ^ aes_xtime(a[2]) ^ a[2] ^ a[3];
    m[2] = a[0] ^ a[1] ^ aes_xtime(a[2]) ^ aes_xtime(a[3]) ^ a[3];
    m[3] = aes_xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ aes_xtime(a[3]);
    return m;
  endfunction

  // Last round skips MixColumns
  always_comb begin
    if (final_round) begin
      mixed = in_beat.state;
    end else begin
      for (int c = 0; c < 4; c++) begin
        mixed.bytes[c] = mix_column(in_beat.state.bytes[c]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_beat.valid;
    end
  end

  // AddRoundKey
  always_ff @(posedge clk) begin
    if (in_beat.valid) begin
      state_q.flat <= mixed.flat ^ round_key.flat;
    end
  end

  assign out_beat = '{valid: valid_q, state: state_q};

endmodule

`default_nettype wire

// ==== design/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

  // ==============================
  // Sizes
  // ==============================
  localparam int aes_block_bits = 128;
  localparam int aes_num_rounds = 10;
  // Index 0 is the initial whitening key
  localparam int aes_num_keys   = aes_num_rounds + 1;

  // ==============================
  // Forward S-box
  // ==============================
  // Entry 0 sits in the top byte so that aes_sbox[x] reads naturally
  localparam logic [0:255][7:0] aes_sbox = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // ==============================
  // State and beat types
  // ==============================

  // Cipher state, seen as one word or as bytes[column][row].
  // Column 0 row 0 is bits 127:120, as in FIPS-197
  typedef union packed {
    logic [aes_block_bits-1:0] flat;
    logic [0:3][0:3][7:0]      bytes;
  } aes_state_u;

  // One pipeline slot
  typedef struct packed {
    logic       valid;
    aes_state_u state;
  } aes_beat_t;

  // Full set of round keys, index 0 to 10
  typedef logic [aes_num_keys-1:0][aes_block_bits-1:0] aes_key_set_t;

  // ==============================
  // GF(2^8) helpers
  // ==============================

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] aes_xtime(input logic [7:0] b);
    logic [7:0] shifted;
    shifted = {b[6:0], 1'b0};
    return b[7] ? (shifted ^ 8'h1b) : shifted;
  endfunction

endpackage

`default_nettype wire

// ==== design/aes_round.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_round
  import aes_pkg::*;
#(
  parameter bit final_round = 1'b0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  aes_beat_t  in_beat,
  input  aes_state_u round_key,
  output aes_beat_t  out_beat
);

  aes_beat_t  sub_beat;
  aes_beat_t  shift_beat;
  aes_state_u shifted;
  aes_state_u shift_state_q;
  logic       shift_valid_q;

  // Stage 1
  aes_sub_bytes u_sub_bytes (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (in_beat),
    .out_beat (sub_beat)
  );

  // Stage 2: ShiftRows, row r rotates left by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[c][r] = sub_beat.state.bytes[(c + r) % 4][r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_valid_q <= 1'b0;
    end else begin
      shift_valid_q <= sub_beat.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sub_beat.valid) begin
      shift_state_q <= shifted;
    end
  end

  assign shift_beat = '{valid: shift_valid_q, state: shift_state_q};

  // Stage 3
  aes_mix_add #(
    .final_round (final_round)
  ) u_mix_add (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_beat   (shift_beat),
    .round_key (round_key),
    .out_beat  (out_beat)
  );

endmodule

`default_nettype wire

// ==== design/aes_sub_bytes.sv ====
`timescale 1ns/1ns
`default_nettype none

module aes_sub_bytes
  import aes_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  aes_beat_t in_beat,
  output aes_beat_t out_beat
);

  aes_state_u sub_state;
  aes_state_u state_q;
  logic       valid_q;

  // Sixteen parallel table lookups
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        sub_state.bytes[c][r] = aes_sbox[in_beat.state.bytes[c][r]];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_beat.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_beat.valid) begin
      state_q <= sub_state;
    end
  end

  assign out_beat = '{valid: valid_q, state: state_q};

endmodule

`default_nettype wire

// ==== tb.f ====
design/aes_pkg.sv
design/aes_issue_ctrl.sv
design/aes_sub_bytes.sv
design/aes_mix_add.sv
design/aes_round.sv
design/aes_encrypt_top.sv
tests/aes_ref_model.sv
tests/tb_aes_encrypt.sv

// ==== tests/aes_ref_model.sv ====
`default_nettype none

package aes_ref_model;
  import aes_pkg::*;

  // Software key schedule, 44 words folded into eleven round keys
  function automatic aes_key_set_t expand_key(input logic [127:0] key);
    logic [31:0]  w [0:43];
    logic [31:0]  t;
    logic [7:0]   rcon;
    aes_key_set_t ks;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = key[127-32*i -: 32];
    end
    for (int i = 4; i < 44; i++) begin
      t = w[i-1];
      if (i % 4 == 0) begin
        // RotWord, SubWord, then the round constant
        t = {t[23:0], t[31:24]};
        t = {aes_sbox[t[31:24]], aes_sbox[t[23:16]], aes_sbox[t[15:8]], aes_sbox[t[7:0]]};
        t[31:24] = t[31:24] ^ rcon;
        rcon = aes_xtime(rcon);
      end
      w[i] = w[i-4] ^ t;
    end
    for (int k = 0; k < aes_num_keys; k++) begin
      ks[k] = {w[4*k], w[4*k+1], w[4*k+2], w[4*k+3]};
    end
    return ks;
  endfunction

  // Whole cipher on a byte array, byte k at bits 127-8k
  function automatic logic [127:0] encrypt_block(input logic [127:0] pt,
                                                 input aes_key_set_t ks);
    logic [7:0]   s [0:15];
    logic [7:0]   t [0:15];
    logic [127:0] word;
    word = pt ^ ks[0];
    for (int rnd = 1; rnd <= aes_num_rounds; rnd++) begin
      for (int k = 0; k < 16; k++) begin
        s[k] = aes_sbox[word[127-8*k -: 8]];
      end
      // Byte (c, r) comes from column c + r of the same row
      for (int k = 0; k < 16; k++) begin
        t[k] = s[4*((k/4 + k%4) % 4) + k%4];
      end
      if (rnd == aes_num_rounds) begin
        s = t;
      end else begin
        for (int c = 0; c < 4; c++) begin
          for (int r = 0; r < 4; r++) begin
            s[4*c+r] = aes_xtime(t[4*c+r]) ^ aes_xtime(t[4*c+(r+1)%4]) ^ t[4*c+(r+1)%4]
                     ^ t[4*c+(r+2)%4] ^ t[4*c+(r+3)%4];
          end
        end
      end
      for (int k = 0; k < 16; k++) begin
        word[127-8*k -: 8] = s[k];
      end
      word = word ^ ks[rnd];
    end
    return word;
  endfunction

endpackage

`default_nettype wire

// ==== tests/tb_aes_encrypt.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_aes_encrypt
  import aes_pkg::*, aes_ref_model::*;
();

  localparam int latency       = 31;
  localparam int ready_timeout = 100;
  localparam int drain_timeout = 200;

  logic         clk;
  logic         rst_n;
  logic         data_valid;
  logic         data_ready;
  aes_state_u   data_in;
  logic         keys_valid;
  aes_key_set_t round_keys;
  aes_state_u   data_out;
  logic         encryption_valid;

  aes_key_set_t model_keys;
  logic [127:0] exp_data [$];
  int           ref_cycle [$];
  int           cycle;
  int           sent_count;
  int           out_count;
  bit           keys_seen;

  aes_encrypt_top UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .data_valid       (data_valid),
    .data_ready       (data_ready),
    .data_in          (data_in),
    .keys_valid       (keys_valid),
    .round_keys       (round_keys),
    .data_out         (data_out),
    .encryption_valid (encryption_valid)
  );

  always #10 clk = ~clk;

  // ==============================
  // Failure reporting
  // ==============================
  task automatic report_failure(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input string exp_s, input string act_s);
    $display("CHECK FAILED time=%0t %s expected %s actual %s", $time, name, exp_s, act_s);
    $display("Test failures found");
    $fatal(1);
  endtask

  // ==============================
  // Scoreboard
  // ==============================
  always @(posedge clk) begin
    cycle++;
    if (!rst_n) begin
      keys_seen = 1'b0;
    end else begin
      assert (!$isunknown(encryption_valid))
        else report_mismatch("encryption_valid", "0 or 1",
                             $sformatf("%b", encryption_valid));
      if (encryption_valid) begin
        if (exp_data.size() == 0) begin
          report_failure("encryption_valid rose with no block in flight");
        end else if (ref_cycle[0] < 0) begin
          report_failure("a block came out before any round keys were loaded");
        end else begin
          assert (data_out.flat == exp_data[0])
            else report_mismatch("data_out", $sformatf("%h", exp_data[0]),
                                 $sformatf("%h", data_out.flat));
          // Valid is seen one edge after the one that raised it
          assert (cycle - ref_cycle[0] == latency + 1)
            else report_mismatch("encryption_valid latency", $sformatf("%0d", latency),
                                 $sformatf("%0d", cycle - ref_cycle[0] - 1));
          void'(exp_data.pop_front());
          void'(ref_cycle.pop_front());
          out_count++;
        end
      end
      if (data_valid && data_ready) begin
        exp_data.push_back(encrypt_block(data_in.flat, model_keys));
        ref_cycle.push_back(keys_seen ? cycle : -1);
      end
      // Blocks that waited for keys start their count here
      if (keys_valid) begin
        keys_seen = 1'b1;
        foreach (ref_cycle[i]) begin
          if (ref_cycle[i] < 0) begin
            ref_cycle[i] = cycle;
          end
        end
      end
    end
  end

  // ==============================
  // Stimulus tasks
  // ==============================
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
  endtask

  function automatic logic [127:0] random_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic set_cipher_key(input logic [127:0] key);
    model_keys = expand_key(key);
  endtask

  task automatic load_keys();
    round_keys = model_keys;
    keys_valid = 1'b1;
    @(negedge clk);
    keys_valid = 1'b0;
  endtask

  // Returns at the falling edge after acceptance with data_valid still high
  task automatic offer_block(input logic [127:0] block, output int waited);
    waited = 0;
    while (!data_ready) begin
      @(negedge clk);
      waited++;
      if (waited > ready_timeout) begin
        report_failure("timed out waiting for data_ready");
      end
    end
    data_in.flat = block;
    data_valid   = 1'b1;
    @(negedge clk);
    sent_count++;
  endtask

  // An offer while data_ready is low must not be taken
  task automatic offer_ignored();
    assert (data_ready == 1'b0)
      else report_mismatch("data_ready", "0", $sformatf("%b", data_ready));
    data_in.flat = random_block();
    data_valid   = 1'b1;
    @(negedge clk);
    data_valid   = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > drain_timeout) begin
        report_failure("timed out waiting for the pipeline to drain");
      end
    end
  endtask

  task automatic stream_blocks(input int count);
    int waited;
    for (int i = 0; i < count; i++) begin
      offer_block(random_block(), waited);
      // Ready drops for exactly one cycle between blocks
      if (i > 0) begin
        assert (waited == 1)
          else report_mismatch("data_ready low cycles", "1", $sformatf("%0d", waited));
      end
    end
    data_valid = 1'b0;
    wait_drain();
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    int waited;
    void'($urandom(2643));
    clk        = 1'b0;
    rst_n      = 1'b0;
    data_valid = 1'b0;
    data_in    = '0;
    keys_valid = 1'b0;
    round_keys = '0;
    model_keys = '0;
    cycle      = 0;
    sent_count = 0;
    out_count  = 0;
    keys_seen  = 1'b0;
    apply_reset();

    assert (data_ready == 1'b1)
      else report_mismatch("data_ready", "1", $sformatf("%b", data_ready));
    assert (encryption_valid == 1'b0)
      else report_mismatch("encryption_valid", "0", $sformatf("%b", encryption_valid));
    repeat (5) @(negedge clk);

    // Known answer from FIPS-197 appendix C.1
    set_cipher_key(128'h000102030405060708090a0b0c0d0e0f);
    assert (encrypt_block(128'h00112233445566778899aabbccddeeff, model_keys) ==
            128'h69c4e0d86a7b0430d8cdb78070b4c55a)
      else report_failure("reference model misses the known answer");
    load_keys();
    offer_block(128'h00112233445566778899aabbccddeeff, waited);
    data_valid = 1'b0;
    wait_drain();

    // Offer during the one low cycle of data_ready
    offer_block(random_block(), waited);
    offer_ignored();
    wait_drain();

    set_cipher_key(random_block());
    load_keys();
    stream_blocks(40);

    // Block arrives before any keys
    apply_reset();
    set_cipher_key(random_block());
    offer_block(random_block(), waited);
    data_valid = 1'b0;
    repeat (3) offer_ignored();
    repeat (40) @(negedge clk);
    load_keys();
    wait_drain();

    // New key set on an empty pipeline
    set_cipher_key(random_block());
    load_keys();
    stream_blocks(8);

    if (out_count == sent_count) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_mismatch("output count", $sformatf("%0d", sent_count),
                      $sformatf("%0d", out_count));
    end
  end

endmodule

`default_nettype wire
